//--- project.f
rtl/rst_pkg.sv
rtl/rst_duration_clamp.sv
rtl/rst_trigger_arbiter.sv
rtl/rst_pulse_timer.sv
rtl/rst_release_sequencer.sv
rtl/rst_manager_top.sv
tb/tb_rst_manager.sv

//--- rtl/rst_duration_clamp.sv
// Duration clamp: registers the requested reset duration bounded to the allowed range
`timescale 1ns/100ps

module rst_duration_clamp
  import rst_pkg::*;
#(
  parameter int MIN_DURATION = 4,
  parameter int MAX_DURATION = 40
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [DUR_W-1:0] duration_req,
  output logic [DUR_W-1:0] clamped_duration
);

  localparam logic [DUR_W-1:0] MIN_D = DUR_W'(MIN_DURATION);
  localparam logic [DUR_W-1:0] MAX_D = DUR_W'(MAX_DURATION);

  // Reset value keeps the timer away from a zero-length pulse
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      clamped_duration <= MIN_D;
    end else if (duration_req < MIN_D) begin
      clamped_duration <= MIN_D;
    end else if (duration_req > MAX_D) begin
      clamped_duration <= MAX_D;
    end else begin
      clamped_duration <= duration_req;
    end
  end

endmodule

//--- rtl/rst_manager_top.sv
// Reset manager top: trigger arbitration, duration clamp, core pulse and domain release
`timescale 1ns/100ps

module rst_manager_top
  import rst_pkg::*;
#(
  parameter int MIN_DURATION = 4,
  parameter int MAX_DURATION = 40,
  parameter int NUM_DOMAINS  = 3,
  parameter int RELEASE_GAP  = 2
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   sw_trigger,
  input  logic                   wdt_expire,
  input  logic [DUR_W-1:0]       duration_req,
  output logic [NUM_DOMAINS-1:0] domain_rst_n,
  output logic                   busy,
  output rst_cause_e             last_cause
);

  logic [DUR_W-1:0] clamped_duration;
  logic             start;
  logic             core_rst;

  rst_duration_clamp #(
    .MIN_DURATION (MIN_DURATION),
    .MAX_DURATION (MAX_DURATION)
  ) u_clamp (
    .clk              (clk),
    .rst_n            (rst_n),
    .duration_req     (duration_req),
    .clamped_duration (clamped_duration)
  );

  rst_trigger_arbiter u_arbiter (
    .clk        (clk),
    .rst_n      (rst_n),
    .sw_trigger (sw_trigger),
    .wdt_expire (wdt_expire),
    .busy       (busy),
    .start      (start),
    .last_cause (last_cause)
  );

  rst_pulse_timer u_timer (
    .clk              (clk),
    .rst_n            (rst_n),
    .start            (start),
    .clamped_duration (clamped_duration),
    .core_rst         (core_rst)
  );

  rst_release_sequencer #(
    .NUM_DOMAINS (NUM_DOMAINS),
    .RELEASE_GAP (RELEASE_GAP)
  ) u_sequencer (
    .clk          (clk),
    .rst_n        (rst_n),
    .core_rst     (core_rst),
    .domain_rst_n (domain_rst_n),
    .busy         (busy)
  );

endmodule

//--- rtl/rst_pkg.sv
// Reset manager shared types: duration width, FSM states and reset cause encoding
package rst_pkg;

  // Width of duration requests and hold counters
  localparam int DUR_W = 16;

  // Source of the most recent accepted reset trigger
  typedef enum logic [1:0] {
    CAUSE_NONE = 2'd0,
    CAUSE_SW   = 2'd1,
    CAUSE_WDT  = 2'd2,
    CAUSE_BOTH = 2'd3
  } rst_cause_e;

  // Core reset pulse timer
  typedef enum logic {
    T_IDLE = 1'b0,
    T_HOLD = 1'b1
  } timer_state_e;

  // Domain release sequencer
  typedef enum logic [1:0] {
    S_IDLE    = 2'd0,
    S_HOLD    = 2'd1,
    S_RELEASE = 2'd2
  } seq_state_e;

endpackage

//--- rtl/rst_pulse_timer.sv
// Reset pulse timer: holds core reset for the duration latched at start
`timescale 1ns/100ps

module rst_pulse_timer
  import rst_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             start,
  input  logic [DUR_W-1:0] clamped_duration,
  output logic             core_rst
);

  timer_state_e     state;
  logic [DUR_W-1:0] cnt;
  logic             last_cycle;

  // Count of one means this is the final held cycle
  assign last_cycle = (cnt <= DUR_W'(1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= T_IDLE;
      cnt      <= '0;
      core_rst <= 1'b0;
    end else begin
      case (state)
        T_IDLE: begin
          if (start) begin
            state    <= T_HOLD;
            cnt      <= clamped_duration;
            core_rst <= 1'b1;
          end
        end

        T_HOLD: begin
          if (last_cycle) begin
            state    <= T_IDLE;
            cnt      <= '0;
            core_rst <= 1'b0;
          end else begin
            cnt <= cnt - DUR_W'(1);
          end
        end

        default: begin
          state    <= T_IDLE;
          core_rst <= 1'b0;
        end
      endcase
    end
  end

endmodule

//--- rtl/rst_release_sequencer.sv
// Release sequencer: holds all domain resets, then releases them in order with a fixed gap
`timescale 1ns/100ps

module rst_release_sequencer
  import rst_pkg::*;
#(
  parameter int NUM_DOMAINS = 3,
  parameter int RELEASE_GAP = 2
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   core_rst,
  output logic [NUM_DOMAINS-1:0] domain_rst_n,
  output logic                   busy
);

  localparam int IDX_W = (NUM_DOMAINS > 1) ? $clog2(NUM_DOMAINS) : 1;
  localparam int GAP_W = (RELEASE_GAP > 1) ? $clog2(RELEASE_GAP + 1) : 1;

  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_DOMAINS - 1);
  localparam logic [GAP_W-1:0] GAP_LOAD = GAP_W'(RELEASE_GAP - 1);

  seq_state_e             state, state_nxt;
  logic [IDX_W-1:0]       idx, idx_nxt;
  logic [GAP_W-1:0]       gap, gap_nxt;
  logic [NUM_DOMAINS-1:0] dom_nxt;
  logic                   rel_now;

  always_comb begin
    state_nxt = state;
    idx_nxt   = idx;
    gap_nxt   = gap;
    dom_nxt   = domain_rst_n;
    rel_now   = 1'b0;

    case (state)
      S_HOLD:    rel_now = ~core_rst;
      S_RELEASE: begin
        if (gap == '0) begin
          rel_now = 1'b1;
        end else begin
          gap_nxt = gap - GAP_W'(1);
        end
      end
      default:   rel_now = 1'b0;
    endcase

    if (rel_now) begin
      dom_nxt[idx] = 1'b1;
      if (idx == LAST_IDX) begin
        state_nxt = S_IDLE;
        idx_nxt   = '0;
      end else begin
        state_nxt = S_RELEASE;
        idx_nxt   = idx + IDX_W'(1);
        gap_nxt   = GAP_LOAD;
      end
    end

    // Core reset wins from any state
    if (core_rst) begin
      state_nxt = S_HOLD;
      dom_nxt   = '0;
      idx_nxt   = '0;
      gap_nxt   = '0;
    end
  end

  // Domains come out of reset held, so the first pass releases them
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= S_RELEASE;
      idx          <= '0;
      gap          <= '0;
      domain_rst_n <= '0;
      busy         <= 1'b0;
    end else begin
      state        <= state_nxt;
      idx          <= idx_nxt;
      gap          <= gap_nxt;
      domain_rst_n <= dom_nxt;
      busy         <= (state_nxt != S_IDLE);
    end
  end

endmodule

//--- rtl/rst_trigger_arbiter.sv
// Trigger arbiter: accepts software or watchdog triggers while idle and records the cause
`timescale 1ns/100ps

module rst_trigger_arbiter
  import rst_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       sw_trigger,
  input  logic       wdt_expire,
  input  logic       busy,
  output logic       start,
  output rst_cause_e last_cause
);

  logic       start_q;
  logic       pending;
  logic       accept;
  rst_cause_e cause_nxt;

  // Start takes two cycles to show up as busy, so both stages block new triggers
  assign pending = start | start_q;
  assign accept  = (sw_trigger | wdt_expire) & ~busy & ~pending;

  always_comb begin
    case ({sw_trigger, wdt_expire})
      2'b11:   cause_nxt = CAUSE_BOTH;
      2'b10:   cause_nxt = CAUSE_SW;
      2'b01:   cause_nxt = CAUSE_WDT;
      default: cause_nxt = CAUSE_NONE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start      <= 1'b0;
      start_q    <= 1'b0;
      last_cause <= CAUSE_NONE;
    end else begin
      start   <= accept;
      start_q <= start;
      // Cause sticks until the next accepted trigger
      if (accept) begin
        last_cause <= cause_nxt;
      end
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the reset manager testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_rst_manager \
  -f project.f -o tb_rst_manager_sim > build.log 2>&1 &&
  ./obj_dir/tb_rst_manager_sim > sim.log 2>&1
grep -q "^Result: PASSED$" sim.log && echo "Simulation passed" ||
  { echo "Simulation failed, see build.log and sim.log"; exit 1; }

//--- tb/tb_rst_manager.sv
// Reset manager testbench with table-driven triggers checked against a cycle-level model
`timescale 1ns/100ps

module tb_rst_manager
  import rst_pkg::*;
();

  localparam int MIN_DURATION = 4;
  localparam int MAX_DURATION = 40;
  localparam int NUM_DOMAINS  = 3;
  localparam int RELEASE_GAP  = 2;
  localparam int NUM_FIXED    = 8;
  localparam int NUM_RAND     = 6;
  localparam int NUM_TESTS    = NUM_FIXED + NUM_RAND;
  localparam int TIMEOUT_NS   =
    (NUM_TESTS + 1) * (MAX_DURATION + NUM_DOMAINS * RELEASE_GAP + 10) * 100;

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic                   sw_trigger;
  logic                   wdt_expire;
  logic [DUR_W-1:0]       duration_req;
  logic [NUM_DOMAINS-1:0] domain_rst_n;
  logic                   busy;
  rst_cause_e             last_cause;

  // Stimulus table
  int         req_tab   [NUM_TESTS];
  logic       sw_tab    [NUM_TESTS];
  logic       wdt_tab   [NUM_TESTS];
  logic       extra_tab [NUM_TESTS];
  int         d_tab     [NUM_TESTS];
  rst_cause_e cause_tab [NUM_TESTS];

  // Reference model state with edge numbers counted from time zero
  int         cyc = 0;
  bit         rst_seen = 1'b0;
  int         fall_edge = 0;
  int         busy_start = 0;
  int         busy_end = 0;
  int         rel_edge [NUM_DOMAINS];
  rst_cause_e model_cause = CAUSE_NONE;
  int         cur_d = MIN_DURATION;
  rst_cause_e cur_cause = CAUSE_NONE;

  int          errors = 0;
  int          checks = 0;
  logic [31:0] lfsr = 32'hb9b8e88a;

  rst_manager_top #(
    .MIN_DURATION (MIN_DURATION),
    .MAX_DURATION (MAX_DURATION),
    .NUM_DOMAINS  (NUM_DOMAINS),
    .RELEASE_GAP  (RELEASE_GAP)
  ) dut0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .sw_trigger   (sw_trigger),
    .wdt_expire   (wdt_expire),
    .duration_req (duration_req),
    .domain_rst_n (domain_rst_n),
    .busy         (busy),
    .last_cause   (last_cause)
  );

  always #50 clk = ~clk;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_byte(output logic [7:0] v);
    v = '0;
    for (int k = 0; k < 8; k++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[6:0], lfsr[0]};
    end
  endtask

  function automatic int bound_duration(input int req);
    if (req < MIN_DURATION) return MIN_DURATION;
    if (req > MAX_DURATION) return MAX_DURATION;
    return req;
  endfunction

  task automatic add_entry(input int idx, input int req, input logic sw, input logic wdt,
                           input logic extra, input int d, input rst_cause_e cause);
    req_tab[idx]   = req;
    sw_tab[idx]    = sw;
    wdt_tab[idx]   = wdt;
    extra_tab[idx] = extra;
    d_tab[idx]     = d;
    cause_tab[idx] = cause;
  endtask

  task automatic next_cycle;
    @(posedge clk);
    #5;
  endtask

  task automatic flag_error(input string msg);
    errors++;
    $display("CHECK FAILED at %0t: %s", $time, msg);
  endtask

  function automatic logic domain_expected(input int i);
    return !(cyc >= fall_edge && cyc < rel_edge[i]);
  endfunction

  function automatic logic busy_expected();
    return (cyc >= busy_start && cyc < busy_end);
  endfunction

  // Staggered release starts on the first edge out of reset and then follows accepted triggers
  always @(posedge clk) begin
    cyc = cyc + 1;
    if (rst_n && !rst_seen) begin
      rst_seen = 1'b1;
      fall_edge = 0;
      for (int i = 0; i < NUM_DOMAINS; i++) rel_edge[i] = cyc + i * RELEASE_GAP;
      busy_start = cyc;
      busy_end = cyc + (NUM_DOMAINS - 1) * RELEASE_GAP;
    end else if (rst_seen && (sw_trigger || wdt_expire) && cyc > busy_end) begin
      fall_edge = cyc + 2;
      for (int i = 0; i < NUM_DOMAINS; i++) begin
        rel_edge[i] = cyc + cur_d + 2 + i * RELEASE_GAP;
      end
      busy_start = cyc + 2;
      busy_end = rel_edge[NUM_DOMAINS-1];
      model_cause = cur_cause;
    end
  end

  always @(negedge clk) begin
    if (!rst_seen) begin
      checks++;
      assert (domain_rst_n == '0 && busy == 1'b0 && last_cause == CAUSE_NONE)
        else flag_error($sformatf("reset state domains %b busy %b cause %s",
                                  domain_rst_n, busy, last_cause.name()));
    end else begin
      for (int i = 0; i < NUM_DOMAINS; i++) begin
        checks++;
        assert (domain_rst_n[i] == domain_expected(i))
          else flag_error($sformatf("domain_rst_n[%0d] is %b, expected %b",
                                    i, domain_rst_n[i], domain_expected(i)));
      end
      checks++;
      assert (busy == busy_expected())
        else flag_error($sformatf("busy is %b, expected %b", busy, busy_expected()));
      checks++;
      assert (last_cause == model_cause)
        else flag_error($sformatf("last_cause is %s, expected %s",
                                  last_cause.name(), model_cause.name()));
    end
  end

  // Request is set during the previous sequence and the trigger fires once busy falls
  task automatic run_entry(input int i);
    duration_req = DUR_W'(req_tab[i]);
    while (busy) next_cycle;
    cur_d = d_tab[i];
    cur_cause = cause_tab[i];
    sw_trigger = sw_tab[i];
    wdt_expire = wdt_tab[i];
    next_cycle;
    // Extra triggers span the start pipeline and the first busy cycles
    if (extra_tab[i]) begin
      sw_trigger = 1'b1;
      wdt_expire = 1'b1;
      repeat (4) next_cycle;
    end
    sw_trigger = 1'b0;
    wdt_expire = 1'b0;
    while (!busy) next_cycle;
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("Run timed out before all table entries completed");
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    logic [7:0] rnd;
    rst_n = 1'b0;
    sw_trigger = 1'b0;
    wdt_expire = 1'b0;
    duration_req = '0;
    add_entry(0, 10, 1'b1, 1'b0, 1'b0, 10, CAUSE_SW);
    add_entry(1, 1, 1'b1, 1'b0, 1'b0, MIN_DURATION, CAUSE_SW);
    add_entry(2, 0, 1'b0, 1'b1, 1'b0, MIN_DURATION, CAUSE_WDT);
    add_entry(3, 1000, 1'b1, 1'b0, 1'b0, MAX_DURATION, CAUSE_SW);
    add_entry(4, 4, 1'b1, 1'b1, 1'b0, 4, CAUSE_BOTH);
    add_entry(5, 40, 1'b0, 1'b1, 1'b0, 40, CAUSE_WDT);
    add_entry(6, 12, 1'b1, 1'b0, 1'b1, 12, CAUSE_SW);
    add_entry(7, 7, 1'b0, 1'b1, 1'b0, 7, CAUSE_WDT);
    for (int i = NUM_FIXED; i < NUM_TESTS; i++) begin
      rand_byte(rnd);
      add_entry(i, int'(rnd), 1'b1, 1'b0, 1'b0, bound_duration(int'(rnd)), CAUSE_SW);
    end

    repeat (5) next_cycle;
    rst_n = 1'b1;
    // Power-up release pass
    while (!busy) next_cycle;

    for (int i = 0; i < NUM_TESTS; i++) run_entry(i);
    while (busy) next_cycle;
    repeat (3) next_cycle;

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
